//--- verilog/csr_consts.svh
// ************************************************
// CSR constants
// ************************************************
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Identification values, MXL=1 with the I extension
`define CSR_MISA_VALUE          32'h4000_0100
`define CSR_MVENDORID           32'd0
`define CSR_MARCHID             32'd0
`define CSR_MIMPID              32'd1
`define CSR_MHARTID             32'd0

// Exception and interrupt cause codes
`define CSR_EXC_ILLEGAL_INSTR   5'd2
`define CSR_IRQ_CODE_MSI        5'd3
`define CSR_IRQ_CODE_MTI        5'd7
`define CSR_IRQ_CODE_MEI        5'd11

// mstatus fields
`define CSR_MSTATUS_MIE_BIT     3
`define CSR_MSTATUS_MPIE_BIT    7
`define CSR_MSTATUS_MPP_LO      11
`define CSR_MSTATUS_MPP_HI      12
`define CSR_MSTATUS_MPRV_BIT    17

// mip and mie layout
`define CSR_MSI_BIT             3
`define CSR_MTI_BIT             7
`define CSR_MEI_BIT             11

`define CSR_MCAUSE_IRQ_BIT      31

`endif

//--- verilog/csr_pkg.sv
// ************************************************
// CSR subsystem types
// ************************************************
package csr_pkg;

    typedef logic [11:0] csr_addr_t;
    typedef logic [31:0] word_t;

    // Supported machine CSR addresses
    typedef enum logic [11:0] {
        CSR_MSTATUS       = 12'h300,
        CSR_MISA          = 12'h301,
        CSR_MIE           = 12'h304,
        CSR_MTVEC         = 12'h305,
        CSR_MCOUNTEREN    = 12'h306,
        CSR_MSTATUSH      = 12'h310,
        CSR_MCOUNTINHIBIT = 12'h320,
        CSR_MSCRATCH      = 12'h340,
        CSR_MEPC          = 12'h341,
        CSR_MCAUSE        = 12'h342,
        CSR_MTVAL         = 12'h343,
        CSR_MIP           = 12'h344,
        CSR_MCYCLE        = 12'hB00,
        CSR_MINSTRET      = 12'hB02,
        CSR_MCYCLEH       = 12'hB80,
        CSR_MINSTRETH     = 12'hB82,
        CSR_MVENDORID     = 12'hF11,
        CSR_MARCHID       = 12'hF12,
        CSR_MIMPID        = 12'hF13,
        CSR_MHARTID       = 12'hF14
    } csr_t;

    typedef enum logic [1:0] {
        PRIV_LVL_U = 2'b00,
        PRIV_LVL_M = 2'b11
    } priv_lvl_e;

    typedef struct packed {
        logic      mie;
        logic      mpie;
        priv_lvl_e mpp;
        logic      mprv;
    } mstatus_t;

    // Mode 0 is direct, 1 is vectored
    typedef struct packed {
        logic [29:0] base;
        logic [1:0]  mode;
    } mtvec_t;

    typedef struct packed {
        logic m_software;
        logic m_timer;
        logic m_external;
    } irqs_t;

    typedef struct packed {
        logic       irq;
        logic [4:0] code;
    } mcause_t;

    typedef enum logic [1:0] {
        CSR_RW,
        CSR_RS,
        CSR_RC
    } csr_op_e;

    // CSR instruction from the core, wdata is rs1 or the immediate
    typedef struct packed {
        logic      valid;
        csr_op_e   op;
        csr_addr_t addr;
        word_t     wdata;
    } csr_req_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] code;
    } exc_req_t;

    typedef struct packed {
        logic  valid;
        word_t pc;
    } redirect_t;

endpackage

//--- verilog/perf_counter.sv
// ************************************************
// 64-bit performance counter
// ************************************************
`timescale 1ns/1ps

module perf_counter
import csr_pkg::*;
(
    input  logic        clk_i,
    input  logic        rstn_i,
    input  logic        inc_en_i,
    input  logic        we_i,
    input  logic        weh_i,
    input  word_t       w_value_i,
    output logic [63:0] value_o
);

    logic [63:0] count_d, count_q;

    // A write to either half wins over counting
    always_comb
    begin
        count_d = count_q;
        if (we_i || weh_i)
        begin
            if (we_i)
                count_d[31:0] = w_value_i;
            if (weh_i)
                count_d[63:32] = w_value_i;
        end
        else if (inc_en_i)
        begin
            count_d = count_q + 64'd1;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
            count_q <= '0;
        else
            count_q <= count_d;
    end

    assign value_o = count_q;

endmodule

//--- verilog/cs_registers.sv
// ************************************************
// Machine mode CSR register file
// ************************************************
`timescale 1ns/1ps
`include "csr_consts.svh"

module cs_registers
import csr_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      csr_re_i,
    input  csr_addr_t csr_raddr_i,
    output word_t     csr_rdata_o,
    input  logic      csr_we_i,
    input  csr_addr_t csr_waddr_i,
    input  word_t     csr_wdata_i,
    output logic      csr_illegal_o,
    output word_t     csr_mepc_o,
    output mtvec_t    csr_mtvec_o,
    output mstatus_t  csr_mstatus_o,
    output priv_lvl_e current_plvl_o,
    output irqs_t     irq_pending_o,
    input  logic      csr_mret_i,
    input  logic      is_trap_i,
    input  mcause_t   mcause_i,
    input  word_t     exc_pc_i,
    input  logic      irq_software_i,
    input  logic      irq_timer_i,
    input  logic      irq_external_i,
    input  logic      instr_ret_i
);

    csr_t csr_raddr, csr_waddr, access_addr;
    logic addr_known, csr_wen;

    priv_lvl_e plvl_d, plvl_q;
    mstatus_t  mstatus_d, mstatus_q;
    mtvec_t    mtvec_d, mtvec_q;
    irqs_t     mie_d, mie_q, mip;
    mcause_t   mcause_d, mcause_q;
    word_t     mscratch_d, mscratch_q;
    word_t     mepc_d, mepc_q;
    word_t     mtval_d, mtval_q;
    // Bit 0 inhibits mcycle, bit 1 inhibits minstret
    logic [1:0] inhibit_d, inhibit_q;

    logic [63:0] mcycle, minstret;
    logic mcycle_we, mcycleh_we, minstret_we, minstreth_we;

    assign csr_raddr = csr_t'(csr_raddr_i);
    assign csr_waddr = csr_t'(csr_waddr_i);
    assign access_addr = csr_we_i ? csr_waddr : csr_raddr;

    always_comb
    begin
        case (access_addr)
            CSR_MSTATUS, CSR_MISA, CSR_MIE, CSR_MTVEC, CSR_MCOUNTEREN,
            CSR_MSTATUSH, CSR_MCOUNTINHIBIT, CSR_MSCRATCH, CSR_MEPC,
            CSR_MCAUSE, CSR_MTVAL, CSR_MIP, CSR_MCYCLE, CSR_MINSTRET,
            CSR_MCYCLEH, CSR_MINSTRETH, CSR_MVENDORID, CSR_MARCHID,
            CSR_MIMPID, CSR_MHARTID:
                addr_known = 1'b1;
            default:
                addr_known = 1'b0;
        endcase
    end

    // Address space 0xC00 and up is read-only
    assign csr_illegal_o = (csr_re_i || csr_we_i) &&
                           (!addr_known || plvl_q == PRIV_LVL_U ||
                            (csr_we_i && csr_waddr_i[11:10] == 2'b11));
    assign csr_wen = csr_we_i && !csr_illegal_o;

    assign mip = '{m_software: irq_software_i, m_timer: irq_timer_i,
                   m_external: irq_external_i};

    always_comb
    begin
        csr_rdata_o = '0;
        if (csr_re_i && !csr_illegal_o)
        begin
            case (csr_raddr)
                CSR_MSTATUS:
                begin
                    csr_rdata_o[`CSR_MSTATUS_MIE_BIT] = mstatus_q.mie;
                    csr_rdata_o[`CSR_MSTATUS_MPIE_BIT] = mstatus_q.mpie;
                    csr_rdata_o[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] = mstatus_q.mpp;
                    csr_rdata_o[`CSR_MSTATUS_MPRV_BIT] = mstatus_q.mprv;
                end
                CSR_MIE:
                begin
                    csr_rdata_o[`CSR_MSI_BIT] = mie_q.m_software;
                    csr_rdata_o[`CSR_MTI_BIT] = mie_q.m_timer;
                    csr_rdata_o[`CSR_MEI_BIT] = mie_q.m_external;
                end
                CSR_MIP:
                begin
                    csr_rdata_o[`CSR_MSI_BIT] = mip.m_software;
                    csr_rdata_o[`CSR_MTI_BIT] = mip.m_timer;
                    csr_rdata_o[`CSR_MEI_BIT] = mip.m_external;
                end
                CSR_MCAUSE:
                begin
                    csr_rdata_o[`CSR_MCAUSE_IRQ_BIT] = mcause_q.irq;
                    csr_rdata_o[4:0] = mcause_q.code;
                end
                CSR_MISA:          csr_rdata_o = `CSR_MISA_VALUE;
                CSR_MVENDORID:     csr_rdata_o = `CSR_MVENDORID;
                CSR_MARCHID:       csr_rdata_o = `CSR_MARCHID;
                CSR_MIMPID:        csr_rdata_o = `CSR_MIMPID;
                CSR_MHARTID:       csr_rdata_o = `CSR_MHARTID;
                CSR_MTVEC:         csr_rdata_o = mtvec_q;
                CSR_MSCRATCH:      csr_rdata_o = mscratch_q;
                CSR_MEPC:          csr_rdata_o = mepc_q;
                CSR_MTVAL:         csr_rdata_o = mtval_q;
                CSR_MCOUNTINHIBIT: csr_rdata_o = {29'd0, inhibit_q[1], 1'b0, inhibit_q[0]};
                CSR_MCYCLE:        csr_rdata_o = mcycle[31:0];
                CSR_MCYCLEH:       csr_rdata_o = mcycle[63:32];
                CSR_MINSTRET:      csr_rdata_o = minstret[31:0];
                CSR_MINSTRETH:     csr_rdata_o = minstret[63:32];
                default:;
            endcase
        end
    end

    always_comb
    begin
        plvl_d = plvl_q;
        mstatus_d = mstatus_q;
        mtvec_d = mtvec_q;
        mie_d = mie_q;
        inhibit_d = inhibit_q;
        mscratch_d = mscratch_q;
        mepc_d = mepc_q;
        mcause_d = mcause_q;
        mtval_d = mtval_q;

        if (csr_wen)
        begin
            case (csr_waddr)
                CSR_MSTATUS:
                begin
                    mstatus_d.mie = csr_wdata_i[`CSR_MSTATUS_MIE_BIT];
                    mstatus_d.mpie = csr_wdata_i[`CSR_MSTATUS_MPIE_BIT];
                    // Only M and U exist, anything else falls back to U
                    mstatus_d.mpp = (csr_wdata_i[`CSR_MSTATUS_MPP_HI:`CSR_MSTATUS_MPP_LO] ==
                                     PRIV_LVL_M) ? PRIV_LVL_M : PRIV_LVL_U;
                    mstatus_d.mprv = csr_wdata_i[`CSR_MSTATUS_MPRV_BIT];
                end
                CSR_MTVEC:
                    mtvec_d = '{base: csr_wdata_i[31:2], mode: {1'b0, csr_wdata_i[0]}};
                CSR_MIE:
                begin
                    mie_d.m_software = csr_wdata_i[`CSR_MSI_BIT];
                    mie_d.m_timer = csr_wdata_i[`CSR_MTI_BIT];
                    mie_d.m_external = csr_wdata_i[`CSR_MEI_BIT];
                end
                CSR_MCOUNTINHIBIT: inhibit_d = {csr_wdata_i[2], csr_wdata_i[0]};
                CSR_MSCRATCH:      mscratch_d = csr_wdata_i;
                CSR_MEPC:          mepc_d = {csr_wdata_i[31:2], 2'b00};
                CSR_MCAUSE:        mcause_d = '{irq: csr_wdata_i[31], code: csr_wdata_i[4:0]};
                CSR_MTVAL:         mtval_d = csr_wdata_i;
                default:;
            endcase
        end

        if (csr_mret_i)
        begin
            plvl_d = mstatus_q.mpp;
            mstatus_d.mie = mstatus_q.mpie;
            mstatus_d.mpie = 1'b1;
            mstatus_d.mpp = PRIV_LVL_U;
            if (mstatus_q.mpp != PRIV_LVL_M)
                mstatus_d.mprv = 1'b0;
        end
        else if (is_trap_i)
        begin
            // Stack the interrupt enable and privilege, then enter M
            plvl_d = PRIV_LVL_M;
            mstatus_d.mpie = mstatus_q.mie;
            mstatus_d.mie = 1'b0;
            mstatus_d.mpp = plvl_q;
            mcause_d = mcause_i;
            mepc_d = exc_pc_i;
            mtval_d = '0;
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i)
    begin
        if (!rstn_i)
        begin
            plvl_q <= PRIV_LVL_M;
            mstatus_q <= '{mie: 1'b0, mpie: 1'b1, mpp: PRIV_LVL_U, mprv: 1'b0};
            mtvec_q <= '0;
            mie_q <= '0;
            inhibit_q <= '0;
            mscratch_q <= '0;
            mepc_q <= '0;
            mcause_q <= '0;
            mtval_q <= '0;
        end
        else
        begin
            plvl_q <= plvl_d;
            mstatus_q <= mstatus_d;
            mtvec_q <= mtvec_d;
            mie_q <= mie_d;
            inhibit_q <= inhibit_d;
            mscratch_q <= mscratch_d;
            mepc_q <= mepc_d;
            mcause_q <= mcause_d;
            mtval_q <= mtval_d;
        end
    end

    assign mcycle_we    = csr_wen && (csr_waddr == CSR_MCYCLE);
    assign mcycleh_we   = csr_wen && (csr_waddr == CSR_MCYCLEH);
    assign minstret_we  = csr_wen && (csr_waddr == CSR_MINSTRET);
    assign minstreth_we = csr_wen && (csr_waddr == CSR_MINSTRETH);

    perf_counter u_mcycle
    (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .inc_en_i  (~inhibit_q[0]),
        .we_i      (mcycle_we),
        .weh_i     (mcycleh_we),
        .w_value_i (csr_wdata_i),
        .value_o   (mcycle)
    );

    perf_counter u_minstret
    (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .inc_en_i  (instr_ret_i & ~inhibit_q[1]),
        .we_i      (minstret_we),
        .weh_i     (minstreth_we),
        .w_value_i (csr_wdata_i),
        .value_o   (minstret)
    );

    assign csr_mepc_o = mepc_q;
    assign csr_mtvec_o = mtvec_q;
    assign csr_mstatus_o = mstatus_q;
    assign current_plvl_o = plvl_q;
    assign irq_pending_o = mip & mie_q;

endmodule

//--- verilog/csr_access.sv
// ************************************************
// CSR instruction access unit
// ************************************************
`timescale 1ns/1ps

module csr_access
import csr_pkg::*;
(
    input  csr_req_t  csr_req_i,
    input  word_t     csr_rdata_i,
    output logic      csr_re_o,
    output logic      csr_we_o,
    output csr_addr_t csr_addr_o,
    output word_t     csr_wdata_o,
    output word_t     csr_rdata_o
);

    logic operand_nz;

    assign operand_nz = |csr_req_i.wdata;

    // Every valid request reads, the result is the old value
    assign csr_re_o = csr_req_i.valid;
    assign csr_addr_o = csr_req_i.addr;
    assign csr_rdata_o = csr_rdata_i;

    always_comb
    begin
        csr_we_o = 1'b0;
        csr_wdata_o = csr_req_i.wdata;
        case (csr_req_i.op)
            CSR_RW:
            begin
                csr_we_o = csr_req_i.valid;
            end
            CSR_RS:
            begin
                // Set and clear with a zero operand leave the CSR alone
                csr_we_o = csr_req_i.valid && operand_nz;
                csr_wdata_o = csr_rdata_i | csr_req_i.wdata;
            end
            CSR_RC:
            begin
                csr_we_o = csr_req_i.valid && operand_nz;
                csr_wdata_o = csr_rdata_i & ~csr_req_i.wdata;
            end
            default:;
        endcase
    end

endmodule

//--- verilog/trap_ctrl.sv
// ************************************************
// Trap and return controller
// ************************************************
`timescale 1ns/1ps
`include "csr_consts.svh"

module trap_ctrl
import csr_pkg::*;
(
    input  exc_req_t  exc_req_i,
    input  logic      csr_illegal_i,
    input  logic      mret_i,
    input  word_t     cur_pc_i,
    input  mstatus_t  mstatus_i,
    input  mtvec_t    mtvec_i,
    input  word_t     mepc_i,
    input  irqs_t     irq_pending_i,
    output logic      is_trap_o,
    output mcause_t   mcause_o,
    output word_t     exc_pc_o,
    output logic      mret_o,
    output redirect_t redirect_o
);

    logic       irq_take;
    logic [4:0] irq_code;
    word_t      trap_base;

    assign trap_base = {mtvec_i.base, 2'b00};
    assign irq_take = mstatus_i.mie && (|irq_pending_i);
    assign exc_pc_o = cur_pc_i;

    // External first, then software, then timer
    always_comb
    begin
        if (irq_pending_i.m_external)
            irq_code = `CSR_IRQ_CODE_MEI;
        else if (irq_pending_i.m_software)
            irq_code = `CSR_IRQ_CODE_MSI;
        else
            irq_code = `CSR_IRQ_CODE_MTI;
    end

    always_comb
    begin
        is_trap_o = 1'b0;
        mret_o = 1'b0;
        mcause_o = '0;
        redirect_o = '0;

        if (mret_i)
        begin
            mret_o = 1'b1;
            redirect_o = '{valid: 1'b1, pc: mepc_i};
        end
        else if (exc_req_i.valid || csr_illegal_i)
        begin
            is_trap_o = 1'b1;
            mcause_o.code = exc_req_i.valid ? exc_req_i.code : `CSR_EXC_ILLEGAL_INSTR;
            redirect_o = '{valid: 1'b1, pc: trap_base};
        end
        else if (irq_take)
        begin
            is_trap_o = 1'b1;
            mcause_o = '{irq: 1'b1, code: irq_code};
            redirect_o.valid = 1'b1;
            // Vectored mode jumps to base + 4 * cause
            if (mtvec_i.mode == 2'd1)
                redirect_o.pc = trap_base + {25'd0, irq_code, 2'b00};
            else
                redirect_o.pc = trap_base;
        end
    end

endmodule

//--- verilog/csr_unit_top.sv
// ************************************************
// Machine CSR subsystem top
// ************************************************
`timescale 1ns/1ps

module csr_unit_top
import csr_pkg::*;
(
    input  logic      clk_i,
    input  logic      rstn_i,
    input  csr_req_t  csr_req_i,
    input  exc_req_t  exc_req_i,
    input  logic      mret_i,
    input  word_t     cur_pc_i,
    input  logic      irq_software_i,
    input  logic      irq_timer_i,
    input  logic      irq_external_i,
    input  logic      instr_ret_i,
    output word_t     csr_rdata_o,
    output logic      csr_illegal_o,
    output redirect_t redirect_o,
    output priv_lvl_e priv_o
);

    logic      csr_re, csr_we, csr_illegal;
    csr_addr_t csr_addr;
    word_t     csr_wdata, csr_rdata;

    // Register state toward the trap controller
    word_t    mepc;
    mtvec_t   mtvec;
    mstatus_t mstatus;
    irqs_t    irq_pending;

    logic    is_trap, mret;
    mcause_t mcause;
    word_t   exc_pc;

    assign csr_illegal_o = csr_illegal;

    csr_access u_access
    (
        .csr_req_i   (csr_req_i),
        .csr_rdata_i (csr_rdata),
        .csr_re_o    (csr_re),
        .csr_we_o    (csr_we),
        .csr_addr_o  (csr_addr),
        .csr_wdata_o (csr_wdata),
        .csr_rdata_o (csr_rdata_o)
    );

    cs_registers u_regs
    (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .csr_re_i       (csr_re),
        .csr_raddr_i    (csr_addr),
        .csr_rdata_o    (csr_rdata),
        .csr_we_i       (csr_we),
        .csr_waddr_i    (csr_addr),
        .csr_wdata_i    (csr_wdata),
        .csr_illegal_o  (csr_illegal),
        .csr_mepc_o     (mepc),
        .csr_mtvec_o    (mtvec),
        .csr_mstatus_o  (mstatus),
        .current_plvl_o (priv_o),
        .irq_pending_o  (irq_pending),
        .csr_mret_i     (mret),
        .is_trap_i      (is_trap),
        .mcause_i       (mcause),
        .exc_pc_i       (exc_pc),
        .irq_software_i (irq_software_i),
        .irq_timer_i    (irq_timer_i),
        .irq_external_i (irq_external_i),
        .instr_ret_i    (instr_ret_i)
    );

    trap_ctrl u_trap
    (
        .exc_req_i     (exc_req_i),
        .csr_illegal_i (csr_illegal),
        .mret_i        (mret_i),
        .cur_pc_i      (cur_pc_i),
        .mstatus_i     (mstatus),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .irq_pending_i (irq_pending),
        .is_trap_o     (is_trap),
        .mcause_o      (mcause),
        .exc_pc_o      (exc_pc),
        .mret_o        (mret),
        .redirect_o    (redirect_o)
    );

endmodule

//--- dv/csr_tb.sv
// ************************************************
// Machine CSR subsystem testbench
// ************************************************
`timescale 1ns/1ps
`include "csr_consts.svh"

module csr_tb
import csr_pkg::*;
();

    typedef enum logic [1:0] {K_CSR, K_EXC, K_MRET, K_IRQ} kind_e;

    typedef struct {
        string      name;
        kind_e      kind;
        csr_op_e    op;
        csr_addr_t  addr;
        word_t      wdata;
        logic [2:0] irq;
        logic       ret;
        word_t      pc;
        logic       rd_chk;
        word_t      exp_rd;
        logic       exp_ill;
        logic       exp_rv;
        word_t      exp_rpc;
        priv_lvl_e  exp_priv;
    } entry_t;

    // Expected field values built from the bit positions
    localparam word_t MIE_M    = 32'd1 << `CSR_MSTATUS_MIE_BIT;
    localparam word_t MPIE_M   = 32'd1 << `CSR_MSTATUS_MPIE_BIT;
    localparam word_t MPP_M    = 32'd3 << `CSR_MSTATUS_MPP_LO;
    localparam word_t MSI_M    = 32'd1 << `CSR_MSI_BIT;
    localparam word_t MTI_M    = 32'd1 << `CSR_MTI_BIT;
    localparam word_t MEI_M    = 32'd1 << `CSR_MEI_BIT;
    localparam word_t IRQ_ALL  = MSI_M | MTI_M | MEI_M;
    localparam word_t IRQ_FLAG = 32'd1 << `CSR_MCAUSE_IRQ_BIT;

    logic      clk, rstn;
    csr_req_t  csr_req;
    exc_req_t  exc_req;
    logic      mret, instr_ret;
    word_t     cur_pc;
    logic      irq_sw, irq_tmr, irq_ext;
    word_t     csr_rdata;
    logic      csr_illegal;
    redirect_t redirect;
    priv_lvl_e priv;

    entry_t table_q[$];
    integer seed = 11;
    integer limit = 0;
    integer cycles = 0;

    csr_unit_top u_dut
    (
        .clk_i          (clk),
        .rstn_i         (rstn),
        .csr_req_i      (csr_req),
        .exc_req_i      (exc_req),
        .mret_i         (mret),
        .cur_pc_i       (cur_pc),
        .irq_software_i (irq_sw),
        .irq_timer_i    (irq_tmr),
        .irq_external_i (irq_ext),
        .instr_ret_i    (instr_ret),
        .csr_rdata_o    (csr_rdata),
        .csr_illegal_o  (csr_illegal),
        .redirect_o     (redirect),
        .priv_o         (priv)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task check_val(input string name, input string what, input word_t exp, input word_t act);
        if (exp !== act)
        begin
            $display("CHECK FAILED %s %s expected 0x%08h actual 0x%08h", name, what, exp, act);
            $display("tests failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task table_push(input string name, input kind_e kind, input csr_op_e op,
                    input csr_addr_t addr, input word_t wdata, input logic [2:0] irq,
                    input logic ret, input word_t pc, input logic rd_chk, input word_t exp_rd,
                    input logic exp_ill, input logic exp_rv, input word_t exp_rpc,
                    input priv_lvl_e exp_priv);
        entry_t e;
        e.name = name;
        e.kind = kind;
        e.op = op;
        e.addr = addr;
        e.wdata = wdata;
        e.irq = irq;
        e.ret = ret;
        e.pc = pc;
        e.rd_chk = rd_chk;
        e.exp_rd = exp_rd;
        e.exp_ill = exp_ill;
        e.exp_rv = exp_rv;
        e.exp_rpc = exp_rpc;
        e.exp_priv = exp_priv;
        table_q.push_back(e);
    endtask

    // Legal M-mode access with no redirect
    task legal_csr(input string name, input csr_op_e op, input csr_addr_t addr,
                   input word_t wdata, input word_t exp_rd);
        table_push(name, K_CSR, op, addr, wdata, 3'b000, 1'b0, 32'h0, 1'b1, exp_rd,
                   1'b0, 1'b0, 32'h0, PRIV_LVL_M);
    endtask

    task idle_cycle(input string name, input logic ret);
        table_push(name, K_IRQ, CSR_RW, 12'h0, 32'h0, 3'b000, ret, 32'h0, 1'b0, 32'h0,
                   1'b0, 1'b0, 32'h0, PRIV_LVL_M);
    endtask

    task build_table;
        word_t scr_a, scr_b, scr_c, rnd;
        scr_a = 32'h1234_5678;
        scr_b = scr_a | 32'h8000_000F;
        scr_c = scr_b & ~32'h0000_0070;
        rnd = $random(seed);

        legal_csr("rst_mstatus", CSR_RS, CSR_MSTATUS, 0, MPIE_M);
        legal_csr("rst_misa", CSR_RS, CSR_MISA, 0, `CSR_MISA_VALUE);
        legal_csr("rst_mimpid", CSR_RS, CSR_MIMPID, 0, `CSR_MIMPID);
        legal_csr("rst_mhartid", CSR_RS, CSR_MHARTID, 0, `CSR_MHARTID);
        // Write to a read-only ID register traps to mtvec, still 0 here
        table_push("wr_mimpid", K_CSR, CSR_RW, CSR_MIMPID, 32'h7, 3'b000, 1'b0, 32'h100,
                   1'b0, 32'h0, 1'b1, 1'b1, 32'h0, PRIV_LVL_M);
        legal_csr("mimpid_kept", CSR_RS, CSR_MIMPID, 0, `CSR_MIMPID);
        legal_csr("ill_mcause", CSR_RS, CSR_MCAUSE, 0, `CSR_EXC_ILLEGAL_INSTR);
        legal_csr("ill_mepc", CSR_RS, CSR_MEPC, 0, 32'h100);
        legal_csr("ill_mstatus", CSR_RS, CSR_MSTATUS, 0, MPP_M);

        legal_csr("scr_rw", CSR_RW, CSR_MSCRATCH, scr_a, 0);
        legal_csr("scr_rs", CSR_RS, CSR_MSCRATCH, 32'h8000_000F, scr_a);
        legal_csr("scr_rc", CSR_RC, CSR_MSCRATCH, 32'h0000_0070, scr_b);
        legal_csr("scr_rs_zero", CSR_RS, CSR_MSCRATCH, 0, scr_c);
        // Clear with zero on a read-only CSR is a plain read
        legal_csr("rc_zero_ro", CSR_RC, CSR_MIMPID, 0, `CSR_MIMPID);
        legal_csr("scr_rw_rand", CSR_RW, CSR_MSCRATCH, rnd, scr_c);
        legal_csr("scr_rand_rd", CSR_RS, CSR_MSCRATCH, 0, rnd);
        legal_csr("mie_rw", CSR_RW, CSR_MIE, 32'hFFFF_FFFF, 0);
        legal_csr("mie_mask", CSR_RS, CSR_MIE, 0, IRQ_ALL);
        legal_csr("mie_rc", CSR_RC, CSR_MIE, MSI_M | MTI_M, IRQ_ALL);
        legal_csr("mie_rd", CSR_RS, CSR_MIE, 0, MEI_M);
        legal_csr("mepc_rw", CSR_RW, CSR_MEPC, 32'h1003, 32'h100);
        legal_csr("mepc_align", CSR_RS, CSR_MEPC, 0, 32'h1000);

        // Freeze mcycle so its value is known, then let it run
        legal_csr("inh_set", CSR_RS, CSR_MCOUNTINHIBIT, 1, 0);
        table_push("mcycle_wr", K_CSR, CSR_RW, CSR_MCYCLE, 100, 3'b000, 1'b0, 32'h0,
                   1'b0, 32'h0, 1'b0, 1'b0, 32'h0, PRIV_LVL_M);
        legal_csr("mcycle_rd0", CSR_RS, CSR_MCYCLE, 0, 100);
        idle_cycle("inh_idle", 1'b0);
        legal_csr("mcycle_held", CSR_RS, CSR_MCYCLE, 0, 100);
        legal_csr("inh_clr", CSR_RC, CSR_MCOUNTINHIBIT, 1, 1);
        legal_csr("mcycle_rd1", CSR_RS, CSR_MCYCLE, 0, 100);
        idle_cycle("cyc_idle0", 1'b0);
        idle_cycle("cyc_idle1", 1'b0);
        legal_csr("mcycle_rd2", CSR_RS, CSR_MCYCLE, 0, 103);
        legal_csr("mcycleh_wr", CSR_RW, CSR_MCYCLEH, 5, 0);
        legal_csr("mcycleh_rd", CSR_RS, CSR_MCYCLEH, 0, 5);
        legal_csr("minstret_wr", CSR_RW, CSR_MINSTRET, 50, 0);
        table_push("minstret_ret", K_CSR, CSR_RS, CSR_MINSTRET, 0, 3'b000, 1'b1, 32'h0,
                   1'b1, 50, 1'b0, 1'b0, 32'h0, PRIV_LVL_M);
        idle_cycle("ret_pulse", 1'b1);
        legal_csr("minstret_rd", CSR_RS, CSR_MINSTRET, 0, 52);

        legal_csr("mtvec_direct", CSR_RW, CSR_MTVEC, 32'h2000, 0);
        legal_csr("mstatus_mie", CSR_RW, CSR_MSTATUS, MIE_M, MPP_M);
        table_push("exc_load", K_EXC, CSR_RW, 12'h0, 32'd5, 3'b000, 1'b0, 32'h400,
                   1'b0, 32'h0, 1'b0, 1'b1, 32'h2000, PRIV_LVL_M);
        legal_csr("exc_mepc", CSR_RS, CSR_MEPC, 0, 32'h400);
        legal_csr("exc_mcause", CSR_RS, CSR_MCAUSE, 0, 5);
        legal_csr("exc_mstatus", CSR_RS, CSR_MSTATUS, 0, MPIE_M | MPP_M);
        legal_csr("mpp_user", CSR_RW, CSR_MSTATUS, MPIE_M, MPIE_M | MPP_M);
        table_push("mret_user", K_MRET, CSR_RW, 12'h0, 32'h0, 3'b000, 1'b0, 32'h0,
                   1'b0, 32'h0, 1'b0, 1'b1, 32'h400, PRIV_LVL_M);
        table_push("user_access", K_CSR, CSR_RS, CSR_MSCRATCH, 0, 3'b000, 1'b0, 32'h500,
                   1'b0, 32'h0, 1'b1, 1'b1, 32'h2000, PRIV_LVL_U);
        legal_csr("user_mcause", CSR_RS, CSR_MCAUSE, 0, `CSR_EXC_ILLEGAL_INSTR);
        legal_csr("user_mepc", CSR_RS, CSR_MEPC, 0, 32'h500);

        // Lines are {external, timer, software}
        table_push("mip_lines", K_CSR, CSR_RS, CSR_MIP, 0, 3'b101, 1'b0, 32'h0,
                   1'b1, MEI_M | MSI_M, 1'b0, 1'b0, 32'h0, PRIV_LVL_M);
        legal_csr("mie_all", CSR_RW, CSR_MIE, IRQ_ALL, MEI_M);
        legal_csr("mtvec_vec", CSR_RW, CSR_MTVEC, 32'h3001, 32'h2000);
        legal_csr("irq_enable", CSR_RS, CSR_MSTATUS, MIE_M, MPIE_M);
        table_push("irq_sw_tmr", K_IRQ, CSR_RW, 12'h0, 32'h0, 3'b011, 1'b0, 32'h600,
                   1'b0, 32'h0, 1'b0, 1'b1, 32'h3000 + 4 * `CSR_IRQ_CODE_MSI, PRIV_LVL_M);
        legal_csr("irq_mcause_sw", CSR_RS, CSR_MCAUSE, 0, IRQ_FLAG | `CSR_IRQ_CODE_MSI);
        legal_csr("irq_reenable", CSR_RS, CSR_MSTATUS, MIE_M, MPIE_M | MPP_M);
        table_push("irq_all", K_IRQ, CSR_RW, 12'h0, 32'h0, 3'b111, 1'b0, 32'h700,
                   1'b0, 32'h0, 1'b0, 1'b1, 32'h3000 + 4 * `CSR_IRQ_CODE_MEI, PRIV_LVL_M);
        legal_csr("irq_mcause_ext", CSR_RS, CSR_MCAUSE, 0, IRQ_FLAG | `CSR_IRQ_CODE_MEI);
    endtask

    task drive_idle;
        csr_req = '0;
        exc_req = '0;
        mret = 1'b0;
        instr_ret = 1'b0;
        cur_pc = '0;
        {irq_ext, irq_tmr, irq_sw} = 3'b000;
    endtask

    // One entry per cycle, outputs sampled mid low phase
    task apply_entry(input int idx);
        entry_t e;
        e = table_q[idx];
        @(negedge clk);
        csr_req.valid = (e.kind == K_CSR);
        csr_req.op = e.op;
        csr_req.addr = e.addr;
        csr_req.wdata = e.wdata;
        exc_req.valid = (e.kind == K_EXC);
        exc_req.code = e.wdata[4:0];
        mret = (e.kind == K_MRET);
        cur_pc = e.pc;
        {irq_ext, irq_tmr, irq_sw} = e.irq;
        instr_ret = e.ret;
        #2;
        if (e.rd_chk)
            check_val(e.name, "rdata", e.exp_rd, csr_rdata);
        check_val(e.name, "illegal", {31'd0, e.exp_ill}, {31'd0, csr_illegal});
        check_val(e.name, "redirect valid", {31'd0, e.exp_rv}, {31'd0, redirect.valid});
        if (e.exp_rv)
            check_val(e.name, "redirect pc", e.exp_rpc, redirect.pc);
        check_val(e.name, "priv", {30'd0, e.exp_priv}, {30'd0, priv});
    endtask

    initial
    begin
        forever
        begin
            @(posedge clk);
            cycles = cycles + 1;
            if (cycles > limit)
            begin
                $display("TIMEOUT the run did not finish within %0d cycles", limit);
                $display("tests failed");
                $fatal(1, "simulation stopped by the watchdog");
            end
        end
    end

    initial
    begin
        rstn = 1'b0;
        drive_idle();
        build_table();
        limit = 20 * table_q.size() + 100;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        for (int i = 0; i < table_q.size(); i++)
            apply_entry(i);
        @(negedge clk);
        drive_idle();
        $display("all tests passed");
        $finish;
    end

endmodule

//--- build.f
+incdir+verilog
verilog/csr_pkg.sv
verilog/perf_counter.sv
verilog/cs_registers.sv
verilog/csr_access.sv
verilog/trap_ctrl.sv
verilog/csr_unit_top.sv
dv/csr_tb.sv
